//--- Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "Test failed"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- apb_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module apb_splitter import periph_map_pkg::*; (
	// Upstream port from the outside master
	input  wire                        psel,
	input  wire                        penable,
	input  wire                        pwrite,
	input  wire [W_PADDR-1:0]          paddr,
	input  wire [W_DATA-1:0]           pwdata,
	output logic [W_DATA-1:0]          prdata,
	output logic                       pready,
	output logic                       pslverr,

	// Per-slave selects
	output wire                        gpio_psel,
	output wire                        pwm_psel,

	// Shared downstream request
	output wire [W_PADDR-W_SLOT-1:0]   slv_paddr,
	output wire                        slv_penable,
	output wire                        slv_pwrite,
	output wire [W_DATA-1:0]           slv_pwdata,

	// Slave responses
	input  wire [W_DATA-1:0]           gpio_prdata,
	input  wire                        gpio_pready,
	input  wire                        gpio_pslverr,
	input  wire [W_DATA-1:0]           pwm_prdata,
	input  wire                        pwm_pready,
	input  wire                        pwm_pslverr
);

slave_e slv_sel;

// ====================
// Address decode
// ====================

always_comb begin
	if (paddr[W_PADDR-1 -: W_SLOT] == GPIO_BASE[W_PADDR-1 -: W_SLOT]) begin
		slv_sel = SLV_GPIO;
	end else if (paddr[W_PADDR-1 -: W_SLOT] == PWM_BASE[W_PADDR-1 -: W_SLOT]) begin
		slv_sel = SLV_PWM;
	end else begin
		slv_sel = SLV_NONE;
	end
end

// Unmapped slots raise no select at all
assign gpio_psel = psel && (slv_sel == SLV_GPIO);
assign pwm_psel  = psel && (slv_sel == SLV_PWM);

// Slaves only see the offset within their slot
assign slv_paddr   = paddr[W_PADDR-W_SLOT-1:0];
assign slv_penable = penable;
assign slv_pwrite  = pwrite;
assign slv_pwdata  = pwdata;

// ====================
// Response mux
// ====================

always_comb begin
	case (slv_sel)
		SLV_GPIO: begin
			prdata  = gpio_prdata;
			pready  = gpio_pready;
			pslverr = gpio_pslverr;
		end
		SLV_PWM: begin
			prdata  = pwm_prdata;
			pready  = pwm_pready;
			pslverr = pwm_pslverr;
		end
		default: begin
			// Answer locally with an error, no wait states
			prdata  = '0;
			pready  = 1'b1;
			pslverr = 1'b1;
		end
	endcase
end

endmodule

`default_nettype wire

//--- gpio.sv
`timescale 1ns/1ps
`default_nettype none

module gpio import periph_map_pkg::*, periph_reg_pkg::*; #(
	parameter int N_PADS = 11
) (
	input  wire                   clk_sys,
	input  wire                   rst_n,

	// APB slave port
	input  wire                   psel,
	input  wire                   penable,
	input  wire                   pwrite,
	input  wire [W_REG_ADDR-1:0]  paddr,
	input  wire [W_DATA-1:0]      pwdata,
	output logic [W_DATA-1:0]     prdata,
	output wire                   pready,
	output wire                   pslverr,

	// Pads
	input  wire [N_PADS-1:0]      padin,
	output wire [N_PADS-1:0]      padout,
	output wire [N_PADS-1:0]      padoe
);

logic [N_PADS-1:0] out_q;
logic [N_PADS-1:0] oe_q;
logic [N_PADS-1:0] in_meta;
logic [N_PADS-1:0] in_sync;

// Write lands on the edge that ends the access cycle
wire wr_en = psel && penable && pwrite;

// ====================
// Registers
// ====================

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		out_q <= GPIO_OUT_RST[N_PADS-1:0];
		oe_q  <= GPIO_OE_RST[N_PADS-1:0];
	end else if (wr_en) begin
		case (paddr)
			GPIO_OUT: out_q <= pwdata[N_PADS-1:0];
			GPIO_OE:  oe_q  <= pwdata[N_PADS-1:0];
			// GPIO_IN is read-only, other offsets ignored
			default: ;
		endcase
	end
end

// Two-flop input synchroniser
always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		in_meta <= '0;
		in_sync <= '0;
	end else begin
		in_meta <= padin;
		in_sync <= in_meta;
	end
end

assign padout = out_q;
assign padoe  = oe_q;

// ====================
// Read path
// ====================

// Bits above N_PADS stay zero
always_comb begin
	prdata = '0;
	case (paddr)
		GPIO_OUT: prdata[N_PADS-1:0] = out_q;
		GPIO_OE:  prdata[N_PADS-1:0] = oe_q;
		GPIO_IN:  prdata[N_PADS-1:0] = in_sync;
		default: ;
	endcase
end

assign pready  = 1'b1;
assign pslverr = 1'b0;

endmodule

`default_nettype wire

//--- periph_map_pkg.sv
`default_nettype none

package periph_map_pkg;

	// ====================
	// Bus widths
	// ====================

	localparam int W_PADDR = 16;
	localparam int W_DATA  = 32;

	// Upper address bits that pick a slave slot
	localparam int W_SLOT = 4;

	// ====================
	// Slave slots
	// ====================

	// One slot per 4 KiB, indexed by paddr[15:12]
	// Slots 2 to 15 once held UART, SPI, PPU, LCD and tbio and are now unmapped
	typedef enum logic [W_SLOT-1:0] {
		SLV_GPIO = 4'h0,
		SLV_PWM  = 4'h1,
		SLV_NONE = 4'hf
	} slave_e;

	// ====================
	// Address map
	// ====================

	localparam logic [W_PADDR-1:0] GPIO_BASE = 16'h0000;
	localparam logic [W_PADDR-1:0] PWM_BASE  = 16'h1000;

endpackage

`default_nettype wire

//--- periph_reg_pkg.sv
`default_nettype none

package periph_reg_pkg;

	// Offset within a slave slot
	localparam int W_REG_ADDR = 12;

	// PWM counter and compare width
	localparam int W_PWM_CNT = 8;

	// ====================
	// GPIO registers
	// ====================

	typedef enum logic [W_REG_ADDR-1:0] {
		GPIO_OUT = 12'h000,
		GPIO_OE  = 12'h004,
		GPIO_IN  = 12'h008
	} gpio_reg_e;

	localparam logic [31:0] GPIO_OUT_RST = 32'h0000_0000;
	localparam logic [31:0] GPIO_OE_RST  = 32'h0000_0000;

	// ====================
	// PWM registers
	// ====================

	// CTRL bit 0 enables the counter
	typedef enum logic [W_REG_ADDR-1:0] {
		PWM_CTRL = 12'h000,
		PWM_CMP  = 12'h004
	} pwm_reg_e;

	localparam logic                 PWM_EN_RST  = 1'b0;
	localparam logic [W_PWM_CNT-1:0] PWM_CMP_RST = '0;

endpackage

`default_nettype wire

//--- periph_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem import periph_map_pkg::*, periph_reg_pkg::*; #(
	parameter int N_PADS = 11
) (
	input  wire                clk_sys,
	input  wire                rst_n,

	// APB port from the outside master
	input  wire                psel,
	input  wire                penable,
	input  wire                pwrite,
	input  wire [W_PADDR-1:0]  paddr,
	input  wire [W_DATA-1:0]   pwdata,
	output wire [W_DATA-1:0]   prdata,
	output wire                pready,
	output wire                pslverr,

	// Pads and backlight
	input  wire [N_PADS-1:0]   padin,
	output wire [N_PADS-1:0]   padout,
	output wire [N_PADS-1:0]   padoe,
	output wire                pwm_out
);

// ====================
// Interconnect
// ====================

wire [W_REG_ADDR-1:0] slv_paddr;
wire                  slv_penable;
wire                  slv_pwrite;
wire [W_DATA-1:0]     slv_pwdata;

wire                  gpio_psel;
wire [W_DATA-1:0]     gpio_prdata;
wire                  gpio_pready;
wire                  gpio_pslverr;

wire                  pwm_psel;
wire [W_DATA-1:0]     pwm_prdata;
wire                  pwm_pready;
wire                  pwm_pslverr;

apb_splitter inst_apb_splitter (
	.psel         (psel),
	.penable      (penable),
	.pwrite       (pwrite),
	.paddr        (paddr),
	.pwdata       (pwdata),
	.prdata       (prdata),
	.pready       (pready),
	.pslverr      (pslverr),
	.gpio_psel    (gpio_psel),
	.pwm_psel     (pwm_psel),
	.slv_paddr    (slv_paddr),
	.slv_penable  (slv_penable),
	.slv_pwrite   (slv_pwrite),
	.slv_pwdata   (slv_pwdata),
	.gpio_prdata  (gpio_prdata),
	.gpio_pready  (gpio_pready),
	.gpio_pslverr (gpio_pslverr),
	.pwm_prdata   (pwm_prdata),
	.pwm_pready   (pwm_pready),
	.pwm_pslverr  (pwm_pslverr)
);

// ====================
// Slaves
// ====================

gpio #(
	.N_PADS (N_PADS)
) inst_gpio (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.psel    (gpio_psel),
	.penable (slv_penable),
	.pwrite  (slv_pwrite),
	.paddr   (slv_paddr),
	.pwdata  (slv_pwdata),
	.prdata  (gpio_prdata),
	.pready  (gpio_pready),
	.pslverr (gpio_pslverr),
	.padin   (padin),
	.padout  (padout),
	.padoe   (padoe)
);

// LCD backlight
pwm_tiny inst_pwm_tiny (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.psel    (pwm_psel),
	.penable (slv_penable),
	.pwrite  (slv_pwrite),
	.paddr   (slv_paddr),
	.pwdata  (slv_pwdata),
	.prdata  (pwm_prdata),
	.pready  (pwm_pready),
	.pslverr (pwm_pslverr),
	.pwm_out (pwm_out)
);

endmodule

`default_nettype wire

//--- pwm_tiny.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_tiny import periph_map_pkg::*, periph_reg_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   rst_n,

	// APB slave port
	input  wire                   psel,
	input  wire                   penable,
	input  wire                   pwrite,
	input  wire [W_REG_ADDR-1:0]  paddr,
	input  wire [W_DATA-1:0]      pwdata,
	output logic [W_DATA-1:0]     prdata,
	output wire                   pready,
	output wire                   pslverr,

	// Backlight output
	output wire                   pwm_out
);

logic                 en_q;
logic [W_PWM_CNT-1:0] cmp_q;
logic [W_PWM_CNT-1:0] ctr_q;
logic                 out_q;

wire wr_en = psel && penable && pwrite;

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		en_q  <= PWM_EN_RST;
		cmp_q <= PWM_CMP_RST;
	end else if (wr_en) begin
		case (paddr)
			PWM_CTRL: en_q  <= pwdata[0];
			PWM_CMP:  cmp_q <= pwdata[W_PWM_CNT-1:0];
			default: ;
		endcase
	end
end

// ====================
// Counter and compare
// ====================

// Free-running, wraps at 2^W_PWM_CNT, parked at zero when disabled
always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		ctr_q <= '0;
		out_q <= 1'b0;
	end else begin
		ctr_q <= en_q ? ctr_q + 1'b1 : '0;
		out_q <= en_q && (ctr_q < cmp_q);
	end
end

assign pwm_out = out_q;

always_comb begin
	prdata = '0;
	case (paddr)
		PWM_CTRL: prdata[0] = en_q;
		PWM_CMP:  prdata[W_PWM_CNT-1:0] = cmp_q;
		default: ;
	endcase
end

assign pready  = 1'b1;
assign pslverr = 1'b0;

endmodule

`default_nettype wire

//--- sim.f
periph_map_pkg.sv
periph_reg_pkg.sv
apb_splitter.sv
gpio.sv
pwm_tiny.sv
periph_subsystem.sv
tb_checker.sv
tb_periph.sv

//--- tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker import periph_map_pkg::*; #(
	parameter int N_PADS = 11
) (
	input  wire                clk_sys,
	input  wire                rst_n,

	// DUT APB port and pins
	input  wire                psel,
	input  wire                penable,
	input  wire [W_PADDR-1:0]  paddr,
	input  wire [W_DATA-1:0]   prdata,
	input  wire                pready,
	input  wire                pslverr,
	input  wire [N_PADS-1:0]   padout,
	input  wire [N_PADS-1:0]   padoe,
	input  wire                pwm_out,

	// Expected values from the stimulus loop
	input  wire                xfer_chk,
	input  wire                exp_rd,
	input  wire [W_DATA-1:0]   exp_prdata,
	input  wire                exp_pslverr,
	input  wire                pin_chk,
	input  wire [N_PADS-1:0]   exp_padout,
	input  wire [N_PADS-1:0]   exp_padoe,
	input  wire                exp_pwm,
	input  wire                win_en,
	input  wire [W_DATA-1:0]   exp_high,
	input  wire                done,
	output int                 err_count
);

int   errs = 0;
int   checks = 0;
int   hi_cnt = 0;
logic win_prev;
logic done_prev;

assign err_count = errs;

task automatic compare(input string name, input logic [W_DATA-1:0] exp,
		input logic [W_DATA-1:0] act);
	checks++;
	if (act !== exp) begin
		errs++;
		$display("[FAIL] time %0t: %s expected 0x%h, got 0x%h (paddr 0x%h)",
			$time, name, exp, act, paddr);
	end
endtask

// Everything is sampled on the rising edge, inputs move on the falling one
always @(posedge clk_sys) begin
	if (!rst_n) begin
		win_prev  <= 1'b0;
		done_prev <= 1'b0;
	end else begin
		// ====================
		// APB access cycle
		// ====================
		if (xfer_chk && psel && penable) begin
			compare("pready", W_DATA'(1'b1), W_DATA'(pready));
			compare("pslverr", W_DATA'(exp_pslverr), W_DATA'(pslverr));
			if (exp_rd) begin
				compare("prdata", exp_prdata, prdata);
			end
		end

		// Pin snapshot
		if (pin_chk) begin
			compare("padout", W_DATA'(exp_padout), W_DATA'(padout));
			compare("padoe", W_DATA'(exp_padoe), W_DATA'(padoe));
			compare("pwm_out", W_DATA'(exp_pwm), W_DATA'(pwm_out));
		end

		// ====================
		// PWM duty window
		// ====================
		win_prev <= win_en;
		if (win_en) begin
			hi_cnt <= (win_prev ? hi_cnt : 0) + (pwm_out ? 1 : 0);
		end
		if (win_prev && !win_en) begin
			compare("pwm_out high count", exp_high, hi_cnt);
		end

		done_prev <= done;
		if (done && !done_prev) begin
			$display("Checks run: %0d, errors: %0d", checks, errs);
		end
	end
end

endmodule

`default_nettype wire

//--- tb_periph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph import periph_map_pkg::*; ();

localparam int N_PADS = 11;
localparam int RST_CYCLES = 16;
localparam logic [W_DATA-1:0] PAD_MASK = {W_DATA{1'b1}} >> (W_DATA - N_PADS);

typedef enum logic [1:0] {
	OP_WR,
	OP_RD,
	OP_PIN,
	OP_WIN
} op_e;

logic clk_sys, rst_n, psel, penable, pwrite;
logic [W_PADDR-1:0] paddr;
logic [W_DATA-1:0] pwdata;
wire [W_DATA-1:0] prdata;
wire pready, pslverr, pwm_out;
logic [N_PADS-1:0] padin;
wire [N_PADS-1:0] padout, padoe;

logic xfer_chk, exp_rd, exp_pslverr, pin_chk, exp_pwm, win_en, done, tbl_ready;
logic [W_DATA-1:0] exp_prdata, exp_high, pad_val, seed;
logic [N_PADS-1:0] exp_padout, exp_padoe;
int err_count;

// Stimulus table held as parallel queues with one row per index
op_e tbl_op[$];
logic [W_PADDR-1:0] tbl_addr[$];
logic [W_DATA-1:0] tbl_wdata[$];
logic [W_DATA-1:0] tbl_exp[$];
logic tbl_err[$];

periph_subsystem #(.N_PADS(N_PADS)) DUT (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.paddr(paddr),
	.pwdata(pwdata),
	.prdata(prdata),
	.pready(pready),
	.pslverr(pslverr),
	.padin(padin),
	.padout(padout),
	.padoe(padoe),
	.pwm_out(pwm_out)
);

tb_checker #(.N_PADS(N_PADS)) CHK (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.paddr(paddr),
	.prdata(prdata),
	.pready(pready),
	.pslverr(pslverr),
	.padout(padout),
	.padoe(padoe),
	.pwm_out(pwm_out),
	.xfer_chk(xfer_chk),
	.exp_rd(exp_rd),
	.exp_prdata(exp_prdata),
	.exp_pslverr(exp_pslverr),
	.pin_chk(pin_chk),
	.exp_padout(exp_padout),
	.exp_padoe(exp_padoe),
	.exp_pwm(exp_pwm),
	.win_en(win_en),
	.exp_high(exp_high),
	.done(done),
	.err_count(err_count)
);

initial begin
	clk_sys = 1'b0;
	forever #5 clk_sys = ~clk_sys;
end

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

task automatic add_entry(input op_e op, input logic [W_PADDR-1:0] addr,
		input logic [W_DATA-1:0] wdata, input logic [W_DATA-1:0] exp, input logic err);
	tbl_op.push_back(op);
	tbl_addr.push_back(addr);
	tbl_wdata.push_back(wdata);
	tbl_exp.push_back(exp);
	tbl_err.push_back(err);
endtask

// OP_PIN rows carry padout in wdata, padoe in exp and pwm_out in err
// OP_WIN rows carry the number of high clocks in 256 in exp
task automatic build_table();
	add_entry(OP_PIN, 16'h0000, 32'h0, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h0000, 32'h0, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h0004, 32'h0, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h1000, 32'h0, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h1004, 32'h0, 32'h0, 1'b0);
	// GPIO registers and pads
	add_entry(OP_WR, 16'h0000, 32'ha5a5_5a5a, 32'h0, 1'b0);
	add_entry(OP_WR, 16'h0004, 32'hffff_f0f0, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h0000, 32'h0, 32'ha5a5_5a5a & PAD_MASK, 1'b0);
	add_entry(OP_RD, 16'h0004, 32'h0, 32'hffff_f0f0 & PAD_MASK, 1'b0);
	add_entry(OP_PIN, 16'h0000, 32'ha5a5_5a5a & PAD_MASK, 32'hffff_f0f0 & PAD_MASK, 1'b0);
	add_entry(OP_RD, 16'h0008, 32'h0, pad_val, 1'b0);
	add_entry(OP_WR, 16'h0008, 32'hffff_ffff, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h0008, 32'h0, pad_val, 1'b0);
	// Unmapped slots answer with an error and touch nothing
	add_entry(OP_WR, 16'h2000, 32'hdead_beef, 32'h0, 1'b1);
	add_entry(OP_RD, 16'h2000, 32'h0, 32'h0, 1'b1);
	add_entry(OP_WR, 16'hf004, 32'h1234_5678, 32'h0, 1'b1);
	add_entry(OP_RD, 16'hf004, 32'h0, 32'h0, 1'b1);
	add_entry(OP_WR, 16'h3000, 32'hffff_ffff, 32'h0, 1'b1);
	add_entry(OP_WR, 16'h5004, 32'h0000_00ff, 32'h0, 1'b1);
	add_entry(OP_RD, 16'h0000, 32'h0, 32'ha5a5_5a5a & PAD_MASK, 1'b0);
	add_entry(OP_RD, 16'h1000, 32'h0, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h1004, 32'h0, 32'h0, 1'b0);
	// Unmapped offsets inside mapped slots
	add_entry(OP_WR, 16'h000c, 32'hffff_ffff, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h000c, 32'h0, 32'h0, 1'b0);
	add_entry(OP_WR, 16'h1008, 32'h0000_00ff, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h1008, 32'h0, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h0004, 32'h0, 32'hffff_f0f0 & PAD_MASK, 1'b0);
	// PWM duty cycle
	add_entry(OP_WR, 16'h1004, 32'h40, 32'h0, 1'b0);
	add_entry(OP_WR, 16'h1000, 32'h1, 32'h0, 1'b0);
	add_entry(OP_RD, 16'h1000, 32'h0, 32'h1, 1'b0);
	add_entry(OP_RD, 16'h1004, 32'h0, 32'h40, 1'b0);
	add_entry(OP_WIN, 16'h0000, 32'h0, 32'd64, 1'b0);
	add_entry(OP_WR, 16'h1004, 32'h0, 32'h0, 1'b0);
	add_entry(OP_WIN, 16'h0000, 32'h0, 32'd0, 1'b0);
	add_entry(OP_WR, 16'h1004, 32'hc0, 32'h0, 1'b0);
	add_entry(OP_WIN, 16'h0000, 32'h0, 32'd192, 1'b0);
	add_entry(OP_WR, 16'h1000, 32'h0, 32'h0, 1'b0);
	add_entry(OP_PIN, 16'h0000, 32'ha5a5_5a5a & PAD_MASK, 32'hffff_f0f0 & PAD_MASK, 1'b0);
	add_entry(OP_RD, 16'h1000, 32'h0, 32'h0, 1'b0);
endtask

task automatic run_entry(input int i);
	case (tbl_op[i])
		OP_WR, OP_RD: begin
			psel    = 1'b1;
			penable = 1'b0;
			pwrite  = (tbl_op[i] == OP_WR);
			paddr   = tbl_addr[i];
			pwdata  = tbl_wdata[i];
			@(negedge clk_sys);
			penable     = 1'b1;
			xfer_chk    = 1'b1;
			exp_rd      = (tbl_op[i] == OP_RD);
			exp_prdata  = tbl_exp[i];
			exp_pslverr = tbl_err[i];
			@(negedge clk_sys);
			psel     = 1'b0;
			penable  = 1'b0;
			xfer_chk = 1'b0;
		end
		OP_PIN: begin
			// One idle clock so a previous write has reached the pins
			@(negedge clk_sys);
			exp_padout = tbl_wdata[i][N_PADS-1:0];
			exp_padoe  = tbl_exp[i][N_PADS-1:0];
			exp_pwm    = tbl_err[i];
			pin_chk    = 1'b1;
			@(negedge clk_sys);
			pin_chk = 1'b0;
		end
		default: begin
			@(negedge clk_sys);
			exp_high = tbl_exp[i];
			win_en   = 1'b1;
			repeat (256) @(negedge clk_sys);
			win_en = 1'b0;
			@(negedge clk_sys);
		end
	endcase
endtask

// ====================
// Main sequence
// ====================
initial begin
	rst_n = 1'b0;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = '0;
	pwdata = '0;
	padin = '0;
	xfer_chk = 1'b0;
	exp_rd = 1'b0;
	exp_pslverr = 1'b0;
	pin_chk = 1'b0;
	exp_pwm = 1'b0;
	win_en = 1'b0;
	done = 1'b0;
	exp_prdata = '0;
	exp_high = '0;
	exp_padout = '0;
	exp_padoe = '0;
	tbl_ready = 1'b0;
	seed = lcg_next(32'd6773);
	pad_val = (seed >> 16) & PAD_MASK;
	build_table();
	tbl_ready = 1'b1;
	repeat (RST_CYCLES) @(negedge clk_sys);
	rst_n = 1'b1;
	// Held well past the synchroniser delay before any GPIO_IN read
	padin = pad_val[N_PADS-1:0];
	repeat (4) @(negedge clk_sys);
	for (int i = 0; i < tbl_op.size(); i++) begin
		run_entry(i);
	end
	done = 1'b1;
	@(negedge clk_sys);
	if (err_count == 0) begin
		$display("Simulation finished: PASS");
	end else begin
		$display("Simulation finished: FAIL");
	end
	$finish;
end

// Watchdog allows twice the expected run length
initial begin
	int n_win;
	int limit;
	n_win = 0;
	wait (tbl_ready);
	foreach (tbl_op[k]) begin
		if (tbl_op[k] == OP_WIN) begin
			n_win++;
		end
	end
	limit = 2 * (RST_CYCLES + 4 + 4 * tbl_op.size() + 260 * n_win);
	repeat (limit) @(posedge clk_sys);
	$display("Timeout: the tests were still running after %0d clock cycles", limit);
	$display("Simulation finished: FAIL");
	$finish;
end

endmodule

`default_nettype wire
